// File: all.f
hdl/bcd_pkg.sv
hdl/cmd_decode.sv
hdl/double_dabble.sv
hdl/digit_format.sv
hdl/bcd_convert_top.sv
verif/bcd_convert_assertions.sv
verif/bcd_convert_tb.sv

// File: Makefile
# Verilator build and run for the BCD converter testbench.

VERILATOR ?= verilator
TOP       ?= bcd_convert_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= Done: no errors

SOURCES := $(wildcard hdl/*.sv) $(wildcard verif/*.sv)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$($(SIM_BIN) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: verif/bcd_convert_tb.sv
`timescale 1ns/1ps

module bcd_convert_tb;

    localparam int clk_period = 4;
    localparam int n_stim = 18;
    localparam int stall_cycles = 150;  // output credits held back at the start.
    localparam int watchdog_cycles = n_stim * 40 + stall_cycles + 200;

    typedef struct packed {
        bcd_pkg::conv_op_e op;
        logic [bcd_pkg::bin_width-1:0] value;
        logic neg;
        int mag;
    } stim_t;

    // opcode, raw value, expected sign, expected magnitude.
    stim_t stim_table [n_stim] = '{
        '{bcd_pkg::op_unsigned,       13'd0,    1'b0, 0},
        '{bcd_pkg::op_unsigned,       13'd8191, 1'b0, 8191},
        '{bcd_pkg::op_unsigned,       13'd4095, 1'b0, 4095},
        '{bcd_pkg::op_signed,         13'h1fff, 1'b1, 1},
        '{bcd_pkg::op_signed,         13'h1000, 1'b1, 4096},
        '{bcd_pkg::op_unsigned,       13'd7,    1'b0, 7},
        '{bcd_pkg::op_unsigned,       13'd100,  1'b0, 100},
        '{bcd_pkg::op_unsigned,       13'd1005, 1'b0, 1005},
        '{bcd_pkg::op_unsigned_blank, 13'd100,  1'b0, 100},
        '{bcd_pkg::op_unsigned_blank, 13'd1005, 1'b0, 1005},
        '{bcd_pkg::op_unsigned_blank, 13'd0,    1'b0, 0},
        '{bcd_pkg::op_signed_blank,   13'h1ff9, 1'b1, 7},
        '{bcd_pkg::op_signed,         13'd4095, 1'b0, 4095},
        '{bcd_pkg::op_signed_blank,   13'd1005, 1'b0, 1005},
        '{bcd_pkg::op_signed,         13'h1c18, 1'b1, 1000},
        '{bcd_pkg::op_unsigned,       13'h1000, 1'b0, 4096},
        '{bcd_pkg::op_signed_blank,   13'h1f9c, 1'b1, 100},
        '{bcd_pkg::op_unsigned_blank, 13'd8060, 1'b0, 8060}
    };

    logic clk;
    logic reset;
    logic in_valid;
    bcd_pkg::conv_cmd_t in_cmd;
    logic in_credit;
    logic out_valid;
    bcd_pkg::conv_result_t out_res;
    logic out_credit;

    bcd_pkg::conv_result_t exp_q [$];
    logic [31:0] lfsr_state = 32'hd362;
    int in_credit_cnt = bcd_pkg::in_credits;
    int out_avail = bcd_pkg::out_credits;
    int owed = 0;
    int stall_left = stall_cycles;
    int sent = 0;
    int received = 0;
    int value_errors = 0;
    int protocol_errors = 0;

    bcd_convert_top dut_i (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_cmd     (in_cmd),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_res    (out_res),
        .out_credit (out_credit)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic fb;
        fb = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], fb};
    endfunction

    task automatic take_bit(output logic b);
        lfsr_state = lfsr_next(lfsr_state);
        b = lfsr_state[0];
    endtask

    // decimal digits of the magnitude with blanks above the top nonzero digit.
    function automatic bcd_pkg::conv_result_t model_result(input stim_t s);
        bcd_pkg::conv_result_t r;
        int rest;
        int top;
        r.negative = s.neg;
        rest = s.mag;
        top = 0;
        for (int i = 0; i < bcd_pkg::bcd_digits; i++) begin
            r.digits[i*4 +: 4] = 4'(rest % 10);
            if (rest % 10 != 0) begin
                top = i;
            end
            rest = rest / 10;
        end
        if (s.op == bcd_pkg::op_unsigned_blank || s.op == bcd_pkg::op_signed_blank) begin
            for (int i = top + 1; i < bcd_pkg::bcd_digits; i++) begin
                r.digits[i*4 +: 4] = bcd_pkg::blank_digit;
            end
        end
        return r;
    endfunction

    task automatic check_digits(input bcd_pkg::conv_result_t got,
                                input bcd_pkg::conv_result_t exp);
        if (got.digits !== exp.digits) begin
            value_errors++;
            $display("FAIL out_res.digits: got %h expected %h", got.digits, exp.digits);
        end
    endtask

    task automatic check_sign(input bcd_pkg::conv_result_t got,
                              input bcd_pkg::conv_result_t exp);
        if (got.negative !== exp.negative) begin
            value_errors++;
            $display("FAIL out_res.negative: got %h expected %h", got.negative, exp.negative);
        end
    endtask

    // outputs are sampled mid-cycle.
    always @(negedge clk) begin : watch_outputs
        bcd_pkg::conv_result_t exp;
        if (sent == 0 && (out_valid || in_credit)) begin
            protocol_errors++;
            $display("output activity seen before any command was sent");
        end
        if (in_credit) begin
            in_credit_cnt++;
            if (in_credit_cnt > bcd_pkg::in_credits) begin
                protocol_errors++;
                $display("more input credits returned than commands sent");
            end
        end
        if (out_valid) begin
            if (out_avail == 0) begin
                protocol_errors++;
                $display("result sent without a granted output credit");
            end
            if (exp_q.size() == 0) begin
                protocol_errors++;
                $display("result arrived when none was expected");
            end else begin
                exp = exp_q.pop_front();
                check_digits(out_res, exp);
                check_sign(out_res, exp);
            end
            received++;
            owed++;
        end
        out_avail = out_avail - (out_valid ? 1 : 0) + (out_credit ? 1 : 0);
    end

    // the downstream side stalls first and is then paced by the LFSR.
    always @(posedge clk) begin : return_credits
        logic b0;
        logic b1;
        #1;
        out_credit = 1'b0;
        if (!reset) begin
            if (stall_left > 0) begin
                stall_left--;
            end else if (owed > 0) begin
                take_bit(b0);
                take_bit(b1);
                if (b0 && b1) begin
                    out_credit = 1'b1;
                    owed--;
                end
            end
        end
    end

    initial begin : drive_commands
        stim_t s;
        int total;
        reset = 1'b1;
        in_valid = 1'b0;
        in_cmd = '0;
        out_credit = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        repeat (3) @(posedge clk);  // idle window after reset.
        #1;
        for (int i = 0; i < n_stim; i++) begin
            while (in_credit_cnt == 0) begin
                @(posedge clk);
                #1;
            end
            s = stim_table[i];
            in_valid = 1'b1;
            in_cmd.op = s.op;
            in_cmd.value = s.value;
            in_credit_cnt--;
            exp_q.push_back(model_result(s));
            sent++;
            @(posedge clk);
            #1;
            in_valid = 1'b0;
        end
        wait (received == n_stim);
        repeat (10) @(posedge clk);
        if (exp_q.size() != 0) begin
            protocol_errors++;
            $display("%0d expected results never arrived", exp_q.size());
        end
        total = value_errors + protocol_errors + dut_i.digit_format_i.fmt_checks_i.fail_count +
                dut_i.cmd_decode_i.dec_checks_i.fail_count;
        $display("errors: %0d value, %0d protocol, %0d total", value_errors, protocol_errors,
                 total);
        if (total == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin : watchdog
        #(watchdog_cycles * clk_period);
        $display("timeout, only %0d of %0d results arrived", received, n_stim);
        $display("Done: errors found");
        $finish;
    end

endmodule

// File: verif/bcd_convert_assertions.sv
`timescale 1ns/1ps

module bcd_convert_assertions (
    input logic                                 clk,
    input logic                                 reset,
    input logic                                 out_valid,
    input logic [bcd_pkg::out_cnt_width-1:0]    credit_cnt,
    input bcd_pkg::conv_result_t                out_res,
    input logic                                 credit_pulse
);

    int fail_count = 0;
    logic digits_ok;

    // each digit is decimal or the blank code.
    always_comb begin
        digits_ok = 1'b1;
        for (int i = 0; i < bcd_pkg::bcd_digits; i++) begin
            if ((out_res.digits[i*4 +: 4] > 4'd9) &&
                (out_res.digits[i*4 +: 4] != bcd_pkg::blank_digit)) begin
                digits_ok = 1'b0;
            end
        end
    end

    send_needs_credit: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> (credit_cnt != '0))
        else begin
            fail_count++;
            $error("out_valid high while the output credit counter is zero");
        end

    digits_in_range: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> digits_ok)
        else begin
            fail_count++;
            $error("output digit outside 0 to 9 and not blank");
        end

    no_credit_in_reset: assert property (@(posedge clk) reset |-> !credit_pulse)
        else begin
            fail_count++;
            $error("credit pulse while reset is high");
        end

endmodule

bind digit_format bcd_convert_assertions fmt_checks_i (
    .clk          (clk),
    .reset        (reset),
    .out_valid    (out_valid),
    .credit_cnt   (credit_cnt),
    .out_res      (out_res),
    .credit_pulse (out_credit)
);

bind cmd_decode bcd_convert_assertions dec_checks_i (
    .clk          (clk),
    .reset        (reset),
    .out_valid    (1'b0),
    .credit_cnt   (bcd_pkg::out_credit_init),
    .out_res      ('0),
    .credit_pulse (in_credit)
);

// File: hdl/bcd_convert_top.sv
`timescale 1ns/1ps

module bcd_convert_top (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   in_valid,
    input  bcd_pkg::conv_cmd_t     in_cmd,
    output logic                   in_credit,
    output logic                   out_valid,
    output bcd_pkg::conv_result_t  out_res,
    input  logic                   out_credit
);

    logic op_valid;
    logic op_take;
    bcd_pkg::conv_operand_t op_data;

    logic res_valid;
    logic res_take;
    logic res_blank;
    bcd_pkg::conv_result_t res_data;

    cmd_decode cmd_decode_i (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_cmd    (in_cmd),
        .in_credit (in_credit),
        .op_valid  (op_valid),
        .op_data   (op_data),
        .op_take   (op_take)
    );

    double_dabble double_dabble_i (
        .clk       (clk),
        .reset     (reset),
        .op_valid  (op_valid),
        .op_data   (op_data),
        .op_take   (op_take),
        .res_valid (res_valid),
        .res_data  (res_data),
        .res_blank (res_blank),
        .res_take  (res_take)
    );

    digit_format digit_format_i (
        .clk        (clk),
        .reset      (reset),
        .res_valid  (res_valid),
        .res_data   (res_data),
        .res_blank  (res_blank),
        .res_take   (res_take),
        .out_valid  (out_valid),
        .out_res    (out_res),
        .out_credit (out_credit)
    );

endmodule

// File: hdl/digit_format.sv
`timescale 1ns/1ps

module digit_format (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   res_valid,
    input  bcd_pkg::conv_result_t  res_data,
    input  logic                   res_blank,
    output logic                   res_take,
    output logic                   out_valid,
    output bcd_pkg::conv_result_t  out_res,
    input  logic                   out_credit
);

    logic [bcd_pkg::out_cnt_width-1:0] credit_cnt;
    logic full;
    logic send;
    bcd_pkg::conv_result_t out_reg;
    bcd_pkg::conv_result_t fmt_res;

    // zeros above the highest nonzero digit become blanks but digit 0 always stays.
    function automatic bcd_pkg::conv_result_t blank_zeros(input bcd_pkg::conv_result_t res);
        bcd_pkg::conv_result_t blanked;
        logic leading;
        blanked = res;
        leading = 1'b1;
        for (int i = bcd_pkg::bcd_digits - 1; i > 0; i--) begin
            if (leading && (res.digits[i*4 +: 4] == 4'd0)) begin
                blanked.digits[i*4 +: 4] = bcd_pkg::blank_digit;
            end else begin
                leading = 1'b0;
            end
        end
        return blanked;
    endfunction

    assign res_take = res_valid && !full;
    assign send = full && (credit_cnt != '0);

    always_comb begin
        if (res_blank) begin
            fmt_res = blank_zeros(res_data);
        end else begin
            fmt_res = res_data;
        end
    end

    always_ff @(posedge clk) begin
        if (res_take) begin
            out_reg <= fmt_res;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            full <= 1'b0;
        end else if (res_take) begin
            full <= 1'b1;
        end else if (send) begin
            full <= 1'b0;
        end
    end

    // a send and a returned credit in one cycle cancel out.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            credit_cnt <= bcd_pkg::out_credit_init;
        end else begin
            case ({send, out_credit})
                2'b10: credit_cnt <= credit_cnt - 1'b1;
                2'b01: credit_cnt <= credit_cnt + 1'b1;
                default: ;
            endcase
        end
    end

    assign out_valid = send;
    assign out_res = out_reg;

endmodule

// File: hdl/double_dabble.sv
`timescale 1ns/1ps

module double_dabble (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    op_valid,
    input  bcd_pkg::conv_operand_t  op_data,
    output logic                    op_take,
    output logic                    res_valid,
    output bcd_pkg::conv_result_t   res_data,
    output logic                    res_blank,
    input  logic                    res_take
);

    bcd_pkg::dabble_state_e state;
    bcd_pkg::dabble_state_e next_state;

    logic [bcd_pkg::shift_cnt_width-1:0] shift_cnt;
    logic [bcd_pkg::bin_width-1:0] mag_sr;
    logic [bcd_pkg::bcd_digits*4-1:0] bcd_sr;
    logic [bcd_pkg::bcd_digits*4-1:0] bcd_adj;
    logic neg_r;
    logic blank_r;

    assign op_take = (state == bcd_pkg::st_idle) && op_valid;
    assign res_valid = (state == bcd_pkg::st_done);

    always_comb begin
        next_state = state;
        case (state)
            bcd_pkg::st_idle: begin
                if (op_take) begin
                    next_state = bcd_pkg::st_shift;
                end
            end
            bcd_pkg::st_shift: begin
                if (shift_cnt == bcd_pkg::last_shift) begin
                    next_state = bcd_pkg::st_done;
                end else begin
                    next_state = bcd_pkg::st_adjust;
                end
            end
            bcd_pkg::st_adjust: next_state = bcd_pkg::st_shift;
            bcd_pkg::st_done: begin
                if (res_take) begin
                    next_state = bcd_pkg::st_idle;
                end
            end
            default: next_state = bcd_pkg::st_idle;
        endcase
    end

    // add 3 to every digit above 4.
    always_comb begin
        bcd_adj = bcd_sr;
        for (int i = 0; i < bcd_pkg::bcd_digits; i++) begin
            if (bcd_sr[i*4 +: 4] > 4'd4) begin
                bcd_adj[i*4 +: 4] = bcd_sr[i*4 +: 4] + 4'd3;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= bcd_pkg::st_idle;
            shift_cnt <= '0;
        end else begin
            state <= next_state;
            if (op_take) begin
                shift_cnt <= '0;
            end else if (state == bcd_pkg::st_shift) begin
                shift_cnt <= shift_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            bcd_pkg::st_idle: begin
                if (op_take) begin
                    mag_sr <= op_data.magnitude;
                    bcd_sr <= '0;
                    neg_r <= op_data.negative;
                    blank_r <= op_data.blank;
                end
            end
            bcd_pkg::st_shift: begin
                bcd_sr <= {bcd_sr[bcd_pkg::bcd_digits*4-2:0], mag_sr[bcd_pkg::bin_width-1]};
                mag_sr <= {mag_sr[bcd_pkg::bin_width-2:0], 1'b0};
            end
            bcd_pkg::st_adjust: bcd_sr <= bcd_adj;
            default: ;
        endcase
    end

    assign res_data.negative = neg_r;
    assign res_data.digits = bcd_sr;
    assign res_blank = blank_r;

endmodule

// File: hdl/cmd_decode.sv
`timescale 1ns/1ps

module cmd_decode (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    in_valid,
    input  bcd_pkg::conv_cmd_t      in_cmd,
    output logic                    in_credit,
    output logic                    op_valid,
    output bcd_pkg::conv_operand_t  op_data,
    input  logic                    op_take
);

    bcd_pkg::conv_cmd_t mem [bcd_pkg::in_credits];

    logic [bcd_pkg::fifo_ptr_width-1:0] wr_ptr;
    logic [bcd_pkg::fifo_ptr_width-1:0] rd_ptr;
    logic [bcd_pkg::fifo_cnt_width-1:0] count;

    logic push;
    logic pop;
    logic is_signed;
    bcd_pkg::conv_cmd_t head;

    assign push = in_valid && (count != bcd_pkg::fifo_depth);  // upstream credits keep this true.
    assign pop = op_take && op_valid;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_cmd;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;  // depth is a power of two.
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    assign op_valid = (count != '0);
    assign in_credit = pop;  // one credit back per entry handed on.

    // decode the head entry into sign, blank flag and magnitude.
    always_comb begin
        head = mem[rd_ptr];
        is_signed = (head.op == bcd_pkg::op_signed) || (head.op == bcd_pkg::op_signed_blank);
        op_data.negative = is_signed && head.value[bcd_pkg::bin_width-1];
        op_data.blank = (head.op == bcd_pkg::op_unsigned_blank) ||
                        (head.op == bcd_pkg::op_signed_blank);
        if (op_data.negative) begin
            op_data.magnitude = ~head.value + 1'b1;  // -4096 maps onto 4096.
        end else begin
            op_data.magnitude = head.value;
        end
    end

endmodule

// File: hdl/bcd_pkg.sv
package bcd_pkg;

    localparam int bin_width = 13;
    localparam int bcd_digits = 4;
    localparam int in_credits = 2;  // equals the decode buffer depth.
    localparam int out_credits = 2;
    localparam logic [3:0] blank_digit = 4'hF;

    // derived widths and constants.
    localparam int fifo_ptr_width = $clog2(in_credits);
    localparam int fifo_cnt_width = $clog2(in_credits + 1);
    localparam int shift_cnt_width = $clog2(bin_width);
    localparam int out_cnt_width = $clog2(out_credits + 1);
    localparam logic [fifo_cnt_width-1:0] fifo_depth = fifo_cnt_width'(in_credits);
    localparam logic [shift_cnt_width-1:0] last_shift = shift_cnt_width'(bin_width - 1);
    localparam logic [out_cnt_width-1:0] out_credit_init = out_cnt_width'(out_credits);

    typedef enum logic [1:0] {
        op_unsigned,
        op_signed,
        op_unsigned_blank,
        op_signed_blank
    } conv_op_e;

    typedef enum logic [1:0] {
        st_idle,
        st_shift,
        st_adjust,
        st_done
    } dabble_state_e;

    typedef struct packed {
        conv_op_e op;
        logic [bin_width-1:0] value;
    } conv_cmd_t;

    typedef struct packed {
        logic negative;
        logic blank;
        logic [bin_width-1:0] magnitude;
    } conv_operand_t;

    typedef struct packed {
        logic negative;
        logic [bcd_digits*4-1:0] digits;  // digit 0 in the low nibble.
    } conv_result_t;

endpackage
